// File: tag_geom_pkg.sv
// geometry of the internal tag space and the tag word types
// import wherever a row, column or {row,col} tag is handled
`default_nettype none

package tag_geom_pkg;

    // ========================================================================
    // geometry
    // ========================================================================
    // number of original IDs that can be active at the same time
    localparam int NUM_ROWS = 4;
    // requests in flight per original ID
    localparam int NUM_COLS = 4;

    // derived widths
    localparam int ROW_W = $clog2(NUM_ROWS);
    localparam int COL_W = $clog2(NUM_COLS);
    // free count runs 0..NUM_COLS, so one bit more than a column index
    localparam int CNT_W = $clog2(NUM_COLS + 1);

    // ========================================================================
    // tag types
    // ========================================================================
    typedef logic [ROW_W-1:0] row_idx_t;
    typedef logic [COL_W-1:0] col_idx_t;
    typedef logic [CNT_W-1:0] free_cnt_t;

    // row sits in the upper bits of the tag word
    typedef struct packed {
        row_idx_t row;
        col_idx_t col;
    } tag_rc_t;

    // flat is what goes out on ARID and comes back on RID,
    // rc is the same word split for row and column steering
    typedef union packed {
        logic [ROW_W+COL_W-1:0] flat;
        tag_rc_t                rc;
    } tag_u;

endpackage

`default_nettype wire

// File: id_map_pkg.sv
// original AXI ID type and the port bundles of the allocate and free paths
// shared by the allocator top, the row binder and the tag map
`default_nettype none

package id_map_pkg;

    import tag_geom_pkg::*;

    // width of the master's ARID/RID space
    localparam int ID_W = 4;

    typedef logic [ID_W-1:0] orig_id_t;

    // allocate strobe with the original ID asking for a tag
    typedef struct packed {
        logic     valid;
        orig_id_t id;
    } alloc_req_t;

    // same-cycle grant whose tag only means something with gnt
    typedef struct packed {
        logic gnt;
        tag_u tag;
    } alloc_rsp_t;

    // retirement strobe with the internal tag seen on RID
    typedef struct packed {
        logic valid;
        tag_u tag;
    } free_req_t;

    // ack is one cycle late, restored_id is same cycle
    typedef struct packed {
        logic     ack;
        orig_id_t restored_id;
    } free_rsp_t;

endpackage

`default_nettype wire

// File: col_free_ring.sv
// cyclic free queue of column indices for one row of the tag space
// pop takes the head column on a grant, a free of this row pushes at the tail
`default_nettype none
`timescale 1ns/1ns

module col_free_ring
    import tag_geom_pkg::*;
#(
    parameter int ROW_IDX = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pop,
    input  id_map_pkg::free_req_t free,
    output col_idx_t              head_col,
    output logic                  has_free,
    output logic                  row_idle
);

    // ring storage, head (pop side), tail (push side) and fill level
    col_idx_t  slot_q [NUM_COLS];
    col_idx_t  head_q;
    col_idx_t  tail_q;
    free_cnt_t count_q;
    free_cnt_t count_d;
    logic      push;

    // pointer step that wraps from the last slot back to slot 0
    function automatic col_idx_t next_ptr(input col_idx_t ptr);
        if (ptr == col_idx_t'(NUM_COLS - 1)) begin
            return '0;
        end
        return ptr + col_idx_t'(1);
    endfunction

    // only frees that target this row land here
    assign push = free.valid && (free.tag.rc.row == row_idx_t'(ROW_IDX));

    // oldest free column is offered to the binder
    assign head_col = slot_q[head_q];
    assign has_free = (count_q != '0);

    // last busy column coming back with no pop on this row in the same cycle
    assign row_idle = push && !pop && (count_q == free_cnt_t'(NUM_COLS - 1));

    // pop and push together leave the count alone
    always_comb begin
        count_d = count_q;
        if (push && !pop) begin
            count_d = count_q + free_cnt_t'(1);
        end else if (pop && !push) begin
            count_d = count_q - free_cnt_t'(1);
        end
    end

    // ========================================================================
    // ring state
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            // all columns free and handed out 0,1,2,3 the first time round
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= free_cnt_t'(NUM_COLS);
            for (int c = 0; c < NUM_COLS; c++) begin
                slot_q[c] <= col_idx_t'(c);
            end
        end else begin
            if (pop) begin
                head_q <= next_ptr(head_q);
            end
            if (push) begin
                slot_q[tail_q] <= free.tag.rc.col;
                tail_q         <= next_ptr(tail_q);
            end
            count_q <= count_d;
        end
    end

    // binder must only pop a row it saw as having a free column
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> (count_q != '0))
        else $error("row %0d popped while empty", ROW_IDX);

    // a push into a full ring means a tag was freed twice
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        push |-> (count_q != free_cnt_t'(NUM_COLS)))
        else $error("row %0d pushed while full", ROW_IDX);

endmodule

`default_nettype wire

// File: row_binder.sv
// sticky row binding of original IDs and the allocate grant decision
// picks the row bound to the request ID, else the lowest unbound row,
// and grants when that row's ring still has a free column
`default_nettype none
`timescale 1ns/1ns

module row_binder
    import tag_geom_pkg::*;
    import id_map_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  alloc_req_t          alloc,
    input  logic [NUM_ROWS-1:0] has_free,
    input  col_idx_t            head_col [NUM_ROWS],
    input  logic [NUM_ROWS-1:0] row_idle,
    output logic [NUM_ROWS-1:0] pop,
    output alloc_rsp_t          alloc_rsp,
    output logic                tag_we
);

    // ========================================================================
    // binding table
    // ========================================================================
    // bound flag per row and the original ID that owns it
    logic [NUM_ROWS-1:0] bound_q;
    orig_id_t            owner_q [NUM_ROWS];

    // row search results
    logic     hit;
    row_idx_t hit_row;
    logic     have_unbound;
    row_idx_t unbound_row;
    row_idx_t chosen_row;
    logic     grant;
    logic     bind_new;

    // first matching row and first unbound row in one pass,
    // each taken only while not yet found
    always_comb begin
        hit          = 1'b0;
        hit_row      = '0;
        have_unbound = 1'b0;
        unbound_row  = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (!hit && bound_q[r] && (owner_q[r] == alloc.id)) begin
                hit     = 1'b1;
                hit_row = row_idx_t'(r);
            end
            if (!have_unbound && !bound_q[r]) begin
                have_unbound = 1'b1;
                unbound_row  = row_idx_t'(r);
            end
        end
    end

    // existing binding wins over a fresh row
    assign chosen_row = hit ? hit_row : unbound_row;

    // refused when every row is taken by other IDs or the own row is drained
    assign grant    = alloc.valid && (hit || have_unbound) && has_free[chosen_row];
    assign bind_new = grant && !hit;
    assign tag_we   = grant;

    // one-hot pop towards the chosen ring
    always_comb begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            pop[r] = grant && (chosen_row == row_idx_t'(r));
        end
    end

    // tag is the chosen row and that ring's head column
    always_comb begin
        alloc_rsp = '0;
        if (grant) begin
            alloc_rsp.gnt        = 1'b1;
            alloc_rsp.tag.rc.row = chosen_row;
            alloc_rsp.tag.rc.col = head_col[chosen_row];
        end
    end

    // ========================================================================
    // binding updates
    // ========================================================================
    // release and a new bind never hit the same row
    // since an idle row was bound and a new bind needs an unbound row
    always_ff @(posedge clk) begin
        if (rst) begin
            bound_q <= '0;
        end else begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                if (row_idle[r]) begin
                    bound_q[r] <= 1'b0;
                end
            end
            if (bind_new) begin
                bound_q[chosen_row] <= 1'b1;
            end
        end
    end

    // owner ID comes from the request that first binds the row
    always_ff @(posedge clk) begin
        if (bind_new) begin
            owner_q[chosen_row] <= alloc.id;
        end
    end

    // ========================================================================
    // checks
    // ========================================================================
    for (genvar i = 0; i < NUM_ROWS; i++) begin : g_chk
        // a ring only drains back to full on a row that was handed out
        a_idle_bound: assert property (@(posedge clk) disable iff (rst)
            row_idle[i] |-> bound_q[i])
            else $error("row %0d went idle while unbound", i);

        // one original ID never owns two rows at once
        for (genvar j = i + 1; j < NUM_ROWS; j++) begin : g_pair
            a_unique_owner: assert property (@(posedge clk) disable iff (rst)
                !(bound_q[i] && bound_q[j] && (owner_q[i] == owner_q[j])))
                else $error("rows %0d and %0d bound to the same ID", i, j);
        end
    end

endmodule

`default_nettype wire

// File: tag_map_mem.sv
// original-ID store per internal tag
// written on every grant, read back as restored_id while a free is requested
`default_nettype none
`timescale 1ns/1ns

module tag_map_mem
    import tag_geom_pkg::*;
    import id_map_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       tag_we,
    input  alloc_rsp_t alloc_rsp,
    input  orig_id_t   alloc_id,
    input  free_req_t  free,
    output free_rsp_t  free_rsp
);

    localparam int NUM_TAGS = NUM_ROWS * NUM_COLS;

    // one entry per flat tag
    orig_id_t            map_q [NUM_TAGS];
    logic                ack_q;
    // one bit per tag that is in flight
    logic [NUM_TAGS-1:0] busy_q;

    // record the requester's ID under the granted tag
    always_ff @(posedge clk) begin
        if (tag_we) begin
            map_q[alloc_rsp.tag.flat] <= alloc_id;
        end
    end

    // ack mirrors the free strobe one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q  <= 1'b0;
            busy_q <= '0;
        end else begin
            ack_q <= free.valid;
            if (free.valid) begin
                busy_q[free.tag.flat] <= 1'b0;
            end
            if (tag_we) begin
                busy_q[alloc_rsp.tag.flat] <= 1'b1;
            end
        end
    end

    // guarded restore that reads as zero with no free pending
    assign free_rsp.restored_id = free.valid ? map_q[free.tag.flat] : '0;
    assign free_rsp.ack         = ack_q;

    // retirement of a tag that was never handed out
    a_free_busy: assert property (@(posedge clk) disable iff (rst)
        free.valid |-> busy_q[free.tag.flat])
        else $error("free of tag %0h that is not outstanding", free.tag.flat);

    // rings must never hand out a column that is still in flight
    a_grant_idle: assert property (@(posedge clk) disable iff (rst)
        tag_we |-> !busy_q[alloc_rsp.tag.flat])
        else $error("grant of tag %0h that is still outstanding", alloc_rsp.tag.flat);

endmodule

`default_nettype wire

// File: tag_alloc_top.sv
// AXI read ID allocator that maps original IDs to internal {row,col} tags
// drive alloc to get a tag for ARID, drive free with the tag from RID
// to get the original ID back and return the tag for reuse
`default_nettype none
`timescale 1ns/1ns

module tag_alloc_top
    import tag_geom_pkg::*;
    import id_map_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  alloc_req_t alloc,
    input  free_req_t  free,
    output alloc_rsp_t alloc_rsp,
    output free_rsp_t  free_rsp
);

    // ========================================================================
    // binder to ring wiring
    // ========================================================================
    // one-hot pop from the binder
    logic [NUM_ROWS-1:0] pop;
    // per-ring status back to the binder
    logic [NUM_ROWS-1:0] has_free;
    logic [NUM_ROWS-1:0] row_idle;
    col_idx_t            head_col [NUM_ROWS];
    // grant doubles as tag map write strobe
    logic                tag_we;

    // row choice and grant
    row_binder u_binder (
        .clk       (clk),
        .rst       (rst),
        .alloc     (alloc),
        .has_free  (has_free),
        .head_col  (head_col),
        .row_idle  (row_idle),
        .pop       (pop),
        .alloc_rsp (alloc_rsp),
        .tag_we    (tag_we)
    );

    // one free ring per row, each filters frees by its own row index
    for (genvar r = 0; r < NUM_ROWS; r++) begin : g_ring
        col_free_ring #(
            .ROW_IDX (r)
        ) u_ring (
            .clk      (clk),
            .rst      (rst),
            .pop      (pop[r]),
            .free     (free),
            .head_col (head_col[r]),
            .has_free (has_free[r]),
            .row_idle (row_idle[r])
        );
    end

    // ========================================================================
    // tag map
    // ========================================================================
    // ID to store comes straight from the request
    tag_map_mem u_map (
        .clk       (clk),
        .rst       (rst),
        .tag_we    (tag_we),
        .alloc_rsp (alloc_rsp),
        .alloc_id  (alloc.id),
        .free      (free),
        .free_rsp  (free_rsp)
    );

endmodule

`default_nettype wire

// File: tb_tag_model.svh
// reference model of the tag allocator, included inside the testbench module
// predict_outputs gives one cycle's responses, advance_model applies that cycle
`ifndef TB_TAG_MODEL_SVH
`define TB_TAG_MODEL_SVH

// expected responses for one clock cycle
typedef struct packed {
    logic     gnt;
    tag_u     tag;
    orig_id_t restored_id;
    logic     ack;
} cycle_exp_t;

// sticky row ownership
logic     row_bound  [NUM_ROWS];
orig_id_t row_owner  [NUM_ROWS];
// one free ring per row, head pops and tail pushes
col_idx_t ring_slot  [NUM_ROWS][NUM_COLS];
int       ring_head  [NUM_ROWS];
int       ring_tail  [NUM_ROWS];
int       ring_count [NUM_ROWS];
// original ID per flat tag and the tags in flight
orig_id_t id_of_tag  [NUM_ROWS*NUM_COLS];
logic     tag_busy   [NUM_ROWS*NUM_COLS];
// free strobe of the previous cycle
logic     ack_next;

function automatic void reset_model();
    for (int r = 0; r < NUM_ROWS; r++) begin
        row_bound[r]  = 1'b0;
        row_owner[r]  = '0;
        ring_head[r]  = 0;
        ring_tail[r]  = 0;
        ring_count[r] = NUM_COLS;
        for (int c = 0; c < NUM_COLS; c++) begin
            ring_slot[r][c] = col_idx_t'(c);
        end
    end
    for (int t = 0; t < NUM_ROWS * NUM_COLS; t++) begin
        id_of_tag[t] = '0;
        tag_busy[t]  = 1'b0;
    end
    ack_next = 1'b0;
endfunction

function automatic cycle_exp_t predict_outputs(input alloc_req_t a, input free_req_t f);
    cycle_exp_t e;
    int         row;
    e   = '0;
    row = -1;
    // an ID keeps the row it already owns
    for (int r = 0; r < NUM_ROWS; r++) begin
        if (row < 0 && row_bound[r] && row_owner[r] == a.id) begin
            row = r;
        end
    end
    // otherwise the lowest row nobody owns
    for (int r = 0; r < NUM_ROWS; r++) begin
        if (row < 0 && !row_bound[r]) begin
            row = r;
        end
    end
    if (a.valid && row >= 0 && ring_count[row] > 0) begin
        e.gnt        = 1'b1;
        e.tag.rc.row = row_idx_t'(row);
        e.tag.rc.col = ring_slot[row][ring_head[row]];
    end
    if (f.valid) begin
        e.restored_id = id_of_tag[f.tag.flat];
    end
    e.ack = ack_next;
    return e;
endfunction

function automatic void advance_model(input alloc_req_t a, input free_req_t f,
                                      input cycle_exp_t e);
    int prow;
    int frow;
    prow = e.tag.rc.row;
    frow = f.tag.rc.row;
    if (f.valid) begin
        tag_busy[f.tag.flat]              = 1'b0;
        ring_slot[frow][ring_tail[frow]]  = f.tag.rc.col;
        ring_tail[frow]                   = (ring_tail[frow] + 1) % NUM_COLS;
        ring_count[frow]                  = ring_count[frow] + 1;
    end
    if (e.gnt) begin
        id_of_tag[e.tag.flat] = a.id;
        tag_busy[e.tag.flat]  = 1'b1;
        ring_head[prow]       = (ring_head[prow] + 1) % NUM_COLS;
        ring_count[prow]      = ring_count[prow] - 1;
        if (!row_bound[prow]) begin
            row_bound[prow] = 1'b1;
            row_owner[prow] = a.id;
        end
    end
    // full again only when the push was not undone by a pop on the same row
    if (f.valid && ring_count[frow] == NUM_COLS) begin
        row_bound[frow] = 1'b0;
    end
    ack_next = f.valid;
endfunction

`endif

// File: tb_tag_alloc.sv
// testbench for the tag allocator
// directed checks of grant, restore and ring order come first,
// then a seeded random mix is compared cycle by cycle with the model
`default_nettype none
`timescale 1ns/1ns

module tb_tag_alloc
    import tag_geom_pkg::*;
    import id_map_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int DIRECTED_CYCLES = 100;
    localparam int RANDOM_CYCLES   = 400;
    localparam int WATCHDOG_NS     = (DIRECTED_CYCLES + RANDOM_CYCLES) * CLK_PERIOD * 2;

    logic       clk;
    logic       rst;
    alloc_req_t alloc;
    free_req_t  free;
    alloc_rsp_t alloc_rsp;
    free_rsp_t  free_rsp;
    int         error_count;
    int         check_count;

    `include "tb_tag_model.svh"

    tag_alloc_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .alloc     (alloc),
        .free      (free),
        .alloc_rsp (alloc_rsp),
        .free_rsp  (free_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        error_count++;
        $display("Fail t=%0t %s exp=%0h got=%0h", $time, name, exp_val, got_val);
    endtask

    // ========================================================================
    // model comparison on the falling edge between input changes and clock
    // ========================================================================
    always @(negedge clk) begin
        cycle_exp_t e;
        if (rst) begin
            reset_model();
        end else begin
            e = predict_outputs(alloc, free);
            check_count++;
            if (alloc_rsp.gnt !== e.gnt) begin
                report_mismatch("alloc_rsp.gnt", e.gnt, alloc_rsp.gnt);
            end
            // tag only carries meaning with a grant
            if (e.gnt && alloc_rsp.tag.flat !== e.tag.flat) begin
                report_mismatch("alloc_rsp.tag", e.tag.flat, alloc_rsp.tag.flat);
            end
            if (free_rsp.restored_id !== e.restored_id) begin
                report_mismatch("free_rsp.restored_id", e.restored_id, free_rsp.restored_id);
            end
            if (free_rsp.ack !== e.ack) begin
                report_mismatch("free_rsp.ack", e.ack, free_rsp.ack);
            end
            advance_model(alloc, free, e);
        end
    end

    // inputs change 2 ns after the rising edge
    task automatic drive_cycle(input logic av, input orig_id_t id, input logic fv,
                               input int row, input int col);
        @(posedge clk);
        #2;
        alloc.valid      = av;
        alloc.id         = id;
        free.valid       = fv;
        free.tag.rc.row  = row_idx_t'(row);
        free.tag.rc.col  = col_idx_t'(col);
    endtask

    // grant is same cycle, so look at the falling edge of the request cycle
    task automatic alloc_once(input orig_id_t id, input logic gnt, input int row, input int col);
        drive_cycle(1'b1, id, 1'b0, 0, 0);
        @(negedge clk);
        if (alloc_rsp.gnt !== gnt) begin
            report_mismatch("alloc_rsp.gnt", gnt, alloc_rsp.gnt);
        end
        if (gnt && (alloc_rsp.tag.rc.row !== row_idx_t'(row))) begin
            report_mismatch("alloc_rsp.tag.rc.row", row, alloc_rsp.tag.rc.row);
        end
        if (gnt && (alloc_rsp.tag.rc.col !== col_idx_t'(col))) begin
            report_mismatch("alloc_rsp.tag.rc.col", col, alloc_rsp.tag.rc.col);
        end
    endtask

    // restore in the free cycle, ack and a zero restore in the cycle after
    task automatic free_once(input int row, input int col, input orig_id_t id);
        drive_cycle(1'b0, '0, 1'b1, row, col);
        @(negedge clk);
        if (free_rsp.restored_id !== id) begin
            report_mismatch("free_rsp.restored_id", id, free_rsp.restored_id);
        end
        drive_cycle(1'b0, '0, 1'b0, 0, 0);
        @(negedge clk);
        if (free_rsp.ack !== 1'b1) begin
            report_mismatch("free_rsp.ack", 1, free_rsp.ack);
        end
        if (free_rsp.restored_id !== '0) begin
            report_mismatch("free_rsp.restored_id", 0, free_rsp.restored_id);
        end
    endtask

    // outstanding tags are read after the last model update
    task automatic drive_random();
        int busy_tags [$];
        @(posedge clk);
        #2;
        for (int i = 0; i < NUM_ROWS * NUM_COLS; i++) begin
            if (tag_busy[i]) begin
                busy_tags.push_back(i);
            end
        end
        alloc.valid = 1'($urandom_range(1, 0));
        alloc.id    = orig_id_t'($urandom_range(5, 0));
        free.valid  = (busy_tags.size() > 0) && ($urandom_range(1, 0) == 1);
        free.tag    = '0;
        if (free.valid) begin
            free.tag.flat = (ROW_W + COL_W)'(busy_tags[$urandom_range(busy_tags.size() - 1, 0)]);
        end
    endtask

    initial begin
        void'($urandom(86));
        rst         = 1'b1;
        alloc       = '0;
        free        = '0;
        error_count = 0;
        check_count = 0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        // one ID fills row 0 in column order, then row 0 is drained
        for (int c = 0; c < NUM_COLS; c++) begin
            alloc_once(4'd5, 1'b1, 0, c);
        end
        alloc_once(4'd5, 1'b0, 0, 0);
        // new IDs take rows 1..3, a fifth ID finds no row
        alloc_once(4'd7, 1'b1, 1, 0);
        alloc_once(4'd9, 1'b1, 2, 0);
        alloc_once(4'd11, 1'b1, 3, 0);
        alloc_once(4'd13, 1'b0, 0, 0);
        // restore path where row 2 drains and unbinds
        free_once(2, 0, 4'd9);
        // columns return in the order they were freed
        free_once(0, 2, 4'd5);
        free_once(0, 0, 4'd5);
        alloc_once(4'd5, 1'b1, 0, 2);
        alloc_once(4'd5, 1'b1, 0, 0);
        // drain row 0 so it becomes the lowest unbound row
        // its head then lands on column 0
        for (int c = 0; c < NUM_COLS; c++) begin
            free_once(0, c, 4'd5);
        end
        alloc_once(4'd14, 1'b1, 0, 0);
        repeat (RANDOM_CYCLES) begin
            drive_random();
        end
        drive_cycle(1'b0, '0, 1'b0, 0, 0);
        repeat (2) @(negedge clk);
        $display("checked %0d cycles, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // stops a hung run
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the test did not finish", WATCHDOG_NS);
        $display("checked %0d cycles, %0d errors", check_count, error_count);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
tag_geom_pkg.sv
id_map_pkg.sv
col_free_ring.sv
row_binder.sv
tag_map_mem.sv
tag_alloc_top.sv
tb_tag_alloc.sv

// File: Bender.yml
package:
  name: tag_alloc

sources:
  - files:
      - tag_geom_pkg.sv
      - id_map_pkg.sv
      - col_free_ring.sv
      - row_binder.sv
      - tag_map_mem.sv
      - tag_alloc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_tag_alloc.sv
